/* rtl/bus_pkg.sv */
package bus_pkg;

    // word addressed bus, byte lanes picked by sel
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // master side request, one beat per stb
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [SEL_W-1:0]  sel;
    } wb_req_t;

    // returned to a master
    typedef struct packed {
        logic              ack;
        logic              stall;
        logic              err;
        logic [DATA_W-1:0] data;
    } wb_rsp_t;

    // what a slave hands back to the router
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] data;
    } dev_rsp_t;

    // region field of the word address, 2MB words per region
    localparam int REGION_HI = 29;
    localparam int REGION_LO = 21;

    typedef enum logic [REGION_HI-REGION_LO:0] {
        REGION_MEM = 9'd0,
        REGION_SYS = 9'd1
    } region_e;

endpackage

/* rtl/periph_pkg.sv */
package periph_pkg;

    // system registers decode the low word address bits only
    localparam int SYS_OFFSET_W = 4;

    typedef enum logic [SYS_OFFSET_W-1:0] {
        SYS_VERSION = 4'h0,
        SYS_SCRATCH = 4'h1,
        SYS_BUSERR  = 4'h2,
        SYS_POWER   = 4'h3,
        SYS_INTR    = 4'h4
    } sysreg_addr_e;

    // build id read back from SYS_VERSION
    localparam logic [31:0] VERSION_WORD = 32'h20191028;

endpackage

/* rtl/soc_bus_top.sv */
module soc_bus_top #(
    parameter int MEM_AW = 8
) (
    input  logic             i_clk,
    input  logic             i_reset,
    input  bus_pkg::wb_req_t i_req_a,
    input  bus_pkg::wb_req_t i_req_b,
    output bus_pkg::wb_rsp_t o_rsp_a,
    output bus_pkg::wb_rsp_t o_rsp_b,
    output logic             o_interrupt
);

    // merged bus after arbitration
    bus_pkg::wb_req_t  bus_req;
    bus_pkg::wb_rsp_t  bus_rsp;

    // per slave
    logic              mem_stb;
    logic              sys_stb;
    bus_pkg::dev_rsp_t mem_rsp;
    bus_pkg::dev_rsp_t sys_rsp;
    logic              bus_err;

    wb_pri_arbiter u_arbiter (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_req_a   (i_req_a),
        .i_req_b   (i_req_b),
        .i_bus_rsp (bus_rsp),
        .o_rsp_a   (o_rsp_a),
        .o_rsp_b   (o_rsp_b),
        .o_bus_req (bus_req)
    );

    wb_bus_router u_router (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_bus_req (bus_req),
        .i_mem_rsp (mem_rsp),
        .i_sys_rsp (sys_rsp),
        .o_mem_stb (mem_stb),
        .o_sys_stb (sys_stb),
        .o_bus_rsp (bus_rsp),
        .o_bus_err (bus_err)
    );

    wb_memdev #(
        .MEM_AW (MEM_AW)
    ) u_mem (
        .i_clk (i_clk),
        .i_stb (mem_stb),
        .i_req (bus_req),
        .o_rsp (mem_rsp)
    );

    wb_sysregs u_sysregs (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_stb       (sys_stb),
        .i_req       (bus_req),
        .i_bus_err   (bus_err),
        .o_rsp       (sys_rsp),
        .o_interrupt (o_interrupt)
    );

endmodule

/* rtl/wb_bus_router.sv */
module wb_bus_router (
    input  logic              i_clk,
    input  logic              i_reset,
    input  bus_pkg::wb_req_t  i_bus_req,
    input  bus_pkg::dev_rsp_t i_mem_rsp,
    input  bus_pkg::dev_rsp_t i_sys_rsp,
    output logic              o_mem_stb,
    output logic              o_sys_stb,
    output bus_pkg::wb_rsp_t  o_bus_rsp,
    output logic              o_bus_err
);

    bus_pkg::region_e           region;
    logic                       mem_hit;
    logic                       sys_hit;
    logic                       ack_q;
    logic                       err_q;
    logic [bus_pkg::DATA_W-1:0] data_q;

    // region from the top address bits
    assign region  = bus_pkg::region_e'(i_bus_req.addr[bus_pkg::REGION_HI:bus_pkg::REGION_LO]);
    assign mem_hit = (region == bus_pkg::REGION_MEM);
    assign sys_hit = (region == bus_pkg::REGION_SYS);

    assign o_mem_stb = i_bus_req.stb && mem_hit;
    assign o_sys_stb = i_bus_req.stb && sys_hit;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= i_mem_rsp.ack || i_sys_rsp.ack;
            // nobody home, answer with err next cycle
            err_q <= i_bus_req.stb && !mem_hit && !sys_hit;
        end
    end

    // sysregs win, zero when idle
    always_ff @(posedge i_clk) begin
        if (i_sys_rsp.ack) begin
            data_q <= i_sys_rsp.data;
        end else if (i_mem_rsp.ack) begin
            data_q <= i_mem_rsp.data;
        end else begin
            data_q <= '0;
        end
    end

    // slaves never stall
    assign o_bus_rsp = '{ack: ack_q, stall: 1'b0, err: err_q, data: data_q};
    assign o_bus_err = err_q;

    // one answer per beat across slave and decode paths
    a_ack_err_excl : assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_bus_rsp.ack && o_bus_rsp.err));

endmodule

/* rtl/wb_memdev.sv */
module wb_memdev #(
    parameter int MEM_AW = 8
) (
    input  logic              i_clk,
    input  logic              i_stb,
    input  bus_pkg::wb_req_t  i_req,
    output bus_pkg::dev_rsp_t o_rsp
);

    logic [bus_pkg::DATA_W-1:0] mem [0:(1 << MEM_AW)-1];
    logic [MEM_AW-1:0]          word;

    // upper address bits already decoded by the router
    assign word = i_req.addr[MEM_AW-1:0];

    // byte lane writes
    always_ff @(posedge i_clk) begin
        if (i_stb && i_req.we) begin
            for (int i = 0; i < bus_pkg::SEL_W; i++) begin
                if (i_req.sel[i]) begin
                    mem[word][8*i +: 8] <= i_req.data[8*i +: 8];
                end
            end
        end
    end

    // single cycle response, read returns the old word on a write
    always_ff @(posedge i_clk) begin
        o_rsp.ack  <= i_stb;
        o_rsp.data <= mem[word];
    end

    // strobes reach this slave only for the memory region
    a_stb_region : assert property (@(posedge i_clk)
        i_stb |->
            (i_req.addr[bus_pkg::REGION_HI:bus_pkg::REGION_LO] == bus_pkg::REGION_MEM));

endmodule

/* rtl/wb_pri_arbiter.sv */
module wb_pri_arbiter (
    input  logic             i_clk,
    input  logic             i_reset,
    input  bus_pkg::wb_req_t i_req_a,
    input  bus_pkg::wb_req_t i_req_b,
    input  bus_pkg::wb_rsp_t i_bus_rsp,
    output bus_pkg::wb_rsp_t o_rsp_a,
    output bus_pkg::wb_rsp_t o_rsp_b,
    output bus_pkg::wb_req_t o_bus_req
);

    typedef enum logic {
        OWN_A,
        OWN_B
    } owner_e;

    owner_e owner;

    // owner keeps the bus for its whole cycle
    // idle bus falls back to A
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            owner <= OWN_A;
        end else begin
            case (owner)
                OWN_A: begin
                    if (!i_req_a.cyc && i_req_b.cyc) begin
                        owner <= OWN_B;
                    end
                end
                OWN_B: begin
                    // A waiting, or nobody at all
                    if (!i_req_b.cyc) begin
                        owner <= OWN_A;
                    end
                end
            endcase
        end
    end

    always_comb begin
        // owner request goes out untouched
        o_bus_req = (owner == OWN_A) ? i_req_a : i_req_b;

        // loser is held off, read data shared by both
        o_rsp_a = '{ack: 1'b0, stall: 1'b1, err: 1'b0, data: i_bus_rsp.data};
        o_rsp_b = '{ack: 1'b0, stall: 1'b1, err: 1'b0, data: i_bus_rsp.data};

        if (owner == OWN_A) begin
            o_rsp_a = i_bus_rsp;
        end else begin
            o_rsp_b = i_bus_rsp;
        end
    end

    // an ack answers a request accepted earlier, so the same master
    // must already have owned the bus in the previous cycle
    a_ack_owner_a : assert property (@(posedge i_clk) disable iff (i_reset)
        o_rsp_a.ack |-> ($past(owner) == OWN_A));

    a_ack_owner_b : assert property (@(posedge i_clk) disable iff (i_reset)
        o_rsp_b.ack |-> ($past(owner) == OWN_B));

endmodule

/* rtl/wb_sysregs.sv */
module wb_sysregs (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_stb,
    input  bus_pkg::wb_req_t  i_req,
    input  logic              i_bus_err,
    output bus_pkg::dev_rsp_t o_rsp,
    output logic              o_interrupt
);

    localparam int DW = bus_pkg::DATA_W;

    periph_pkg::sysreg_addr_e   reg_sel;
    logic                       wr_en;
    logic [DW-1:0]              scratch;
    logic [bus_pkg::ADDR_W-1:0] buserr_addr;
    logic [DW-1:0]              power_cnt;
    logic                       intr_flag;

    assign reg_sel = periph_pkg::sysreg_addr_e'(i_req.addr[periph_pkg::SYS_OFFSET_W-1:0]);
    assign wr_en   = i_stb && i_req.we;

    assign o_interrupt = intr_flag;

    // writable registers
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            intr_flag <= 1'b0;
        end else if (wr_en && (reg_sel == periph_pkg::SYS_INTR)) begin
            intr_flag <= i_req.data[0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en && (reg_sel == periph_pkg::SYS_SCRATCH)) begin
            scratch <= i_req.data;
        end
    end

    // err pulse lines up with the failing address still on the bus
    always_ff @(posedge i_clk) begin
        if (i_bus_err) begin
            buserr_addr <= i_req.addr;
        end
    end

    // cycles since reset, top bit sticky after the first wrap
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            power_cnt <= '0;
        end else if (!power_cnt[DW-1]) begin
            power_cnt <= power_cnt + DW'(1);
        end else begin
            power_cnt[DW-2:0] <= power_cnt[DW-2:0] + (DW-1)'(1);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rsp.ack <= 1'b0;
        end else begin
            o_rsp.ack <= i_stb;
        end
    end

    // read mux, registered with the ack
    always_ff @(posedge i_clk) begin
        case (reg_sel)
            periph_pkg::SYS_VERSION: o_rsp.data <= periph_pkg::VERSION_WORD;
            periph_pkg::SYS_SCRATCH: o_rsp.data <= scratch;
            periph_pkg::SYS_BUSERR:  o_rsp.data <= {buserr_addr, 2'b00};
            periph_pkg::SYS_POWER:   o_rsp.data <= power_cnt;
            periph_pkg::SYS_INTR:    o_rsp.data <= {{(DW-1){1'b0}}, intr_flag};
            default:                 o_rsp.data <= '0;
        endcase
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the bus fabric testbench with verilator, run it, grade the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module soc_bus_tb -f soc_bus_top.f -o soc_bus_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/soc_bus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
exit 1

/* soc_bus_top.f */
rtl/bus_pkg.sv
rtl/periph_pkg.sv
rtl/wb_pri_arbiter.sv
rtl/wb_memdev.sv
rtl/wb_sysregs.sv
rtl/wb_bus_router.sv
rtl/soc_bus_top.sv
testbench/soc_bus_tb.sv

/* testbench/soc_bus_tb.sv */
module soc_bus_tb;

    localparam int TIMEOUT = 50;

    logic             clk = 1'b0;
    logic             reset;
    bus_pkg::wb_req_t req [2];
    bus_pkg::wb_rsp_t rsp [2];
    logic             interrupt;

    // expectations per master, held until the next access starts
    logic [31:0] exp_data [2];
    logic        check_data [2];
    logic        unmapped [2];
    logic        intr_chk;
    logic        exp_intr;
    logic [31:0] ref_mem [0:255];
    string       test_name;
    int          seed = 82740;
    int          cycle = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          accesses = 0;

    soc_bus_top #(.MEM_AW(8)) dut0 (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_req_a     (req[0]),
        .i_req_b     (req[1]),
        .o_rsp_a     (rsp[0]),
        .o_rsp_b     (rsp[1]),
        .o_interrupt (interrupt)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    for (genvar m = 0; m < 2; m++) begin : g_master_chk
        logic acc;
        // beat taken when stb meets a low stall
        assign acc = req[m].stb && !rsp[m].stall;

        // mapped slaves answer 2 edges after the accept edge
        a_ack_timing : assert property (@(posedge clk) disable iff (reset)
            rsp[m].ack == $past(acc && !unmapped[m], 2))
        else begin
            errors++;
            $display("** Error %s: master %0d ack, expected %b, actual %b",
                     test_name, m, !$sampled(rsp[m].ack), $sampled(rsp[m].ack));
        end

        // unmapped region answers with err on the very next edge
        a_err_timing : assert property (@(posedge clk) disable iff (reset)
            rsp[m].err == $past(acc && unmapped[m], 1))
        else begin
            errors++;
            $display("** Error %s: master %0d err, expected %b, actual %b",
                     test_name, m, !$sampled(rsp[m].err), $sampled(rsp[m].err));
        end

        a_read_data : assert property (@(posedge clk) disable iff (reset)
            (rsp[m].ack && check_data[m]) |-> (rsp[m].data == exp_data[m]))
        else begin
            errors++;
            $display("** Error %s: master %0d data, expected %h, actual %h",
                     test_name, m, exp_data[m], $sampled(rsp[m].data));
        end
    end

    a_intr_level : assert property (@(posedge clk) disable iff (reset)
        (rsp[0].ack && intr_chk) |-> (interrupt == exp_intr))
    else begin
        errors++;
        $display("** Error %s: interrupt, expected %b, actual %b",
                 test_name, exp_intr, $sampled(interrupt));
    end

    // B must wait while A is being answered
    a_b_stalled : assert property (@(posedge clk) disable iff (reset)
        (rsp[0].ack && req[1].stb) |-> rsp[1].stall)
    else begin
        errors++;
        $display("%s: master B was not stalled while master A was answered", test_name);
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] sel);
        logic [31:0] w;
        w = old_w;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                w[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return w;
    endfunction

    function automatic logic [29:0] mem_addr(input logic [7:0] w);
        return {22'd0, w};
    endfunction

    // region 1 holds the system registers
    function automatic logic [29:0] sys_addr(input logic [3:0] off);
        return {9'd1, 17'd0, off};
    endfunction

    task automatic finish_run();
        $display("accesses %0d, errors %0d, timeouts %0d", accesses, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what, input int m);
        timeouts++;
        $display("master %0d timed out waiting for %s in test %s", m, what, test_name);
        finish_run();
    endtask

    // one single access, driven on the falling edge
    task automatic master_access(input int m, input logic we, input logic [29:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] sel,
                                 input logic chk, input logic [31:0] exp_word,
                                 input logic bad, output logic [31:0] rdata,
                                 output int acc_cycle);
        int n;
        @(negedge clk);
        exp_data[m]   = exp_word;
        check_data[m] = chk;
        unmapped[m]   = bad;
        req[m] = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, data: wdata, sel: sel};
        // stall follows the owner register, so its level now holds for the next edge
        n = 0;
        while (rsp[m].stall && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            timeout_fail("accept", m);
        end else begin
            acc_cycle = cycle;
            @(negedge clk);
            req[m].stb = 1'b0;
            n = 0;
            while (!(rsp[m].ack || rsp[m].err) && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (n >= TIMEOUT) begin
                timeout_fail("ack or err", m);
            end else begin
                rdata = rsp[m].data;
                // cyc and addr held across the answering edge
                // sysregs latches addr there on a bus error
                @(negedge clk);
                req[m].cyc = 1'b0;
                accesses++;
            end
        end
    endtask

    task automatic bus_write(input int m, input logic [29:0] addr, input logic [31:0] data,
                             input logic [3:0] sel);
        logic [31:0] rd;
        int          c;
        master_access(m, 1'b1, addr, data, sel, 1'b0, 32'd0, 1'b0, rd, c);
    endtask

    task automatic bus_read(input int m, input logic [29:0] addr, input logic [31:0] exp_word);
        logic [31:0] rd;
        int          c;
        master_access(m, 1'b0, addr, 32'd0, 4'hf, 1'b1, exp_word, 1'b0, rd, c);
    endtask

    initial begin
        logic [7:0]  a;
        logic [7:0]  b;
        logic [31:0] d;
        logic [31:0] d2;
        logic [3:0]  sel;
        logic [29:0] bad_addr;
        int          c1;
        int          c2;

        req[0] = '0;
        req[1] = '0;
        for (int m = 0; m < 2; m++) begin
            exp_data[m]   = '0;
            check_data[m] = 1'b0;
            unmapped[m]   = 1'b0;
        end
        intr_chk  = 1'b0;
        exp_intr  = 1'b0;
        test_name = "reset";
        reset     = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // 16 distinct words, 37 is odd so i*37 never repeats mod 256
        test_name = "memory";
        for (int i = 0; i < 16; i++) begin
            a = 8'(i * 37);
            ref_mem[a] = $random(seed);
            bus_write(0, mem_addr(a), ref_mem[a], 4'hf);
        end
        for (int i = 0; i < 32; i++) begin
            a   = 8'(($random(seed) & 15) * 37);
            d   = $random(seed);
            sel = 4'($random(seed));
            ref_mem[a] = merge_bytes(ref_mem[a], d, sel);
            bus_write(0, mem_addr(a), d, sel);
        end
        for (int i = 0; i < 16; i++) begin
            a = 8'(i * 37);
            bus_read(0, mem_addr(a), ref_mem[a]);
        end

        test_name = "version and scratch";
        bus_read(0, sys_addr(periph_pkg::SYS_VERSION), periph_pkg::VERSION_WORD);
        d = $random(seed);
        bus_write(0, sys_addr(periph_pkg::SYS_SCRATCH), d, 4'hf);
        bus_read(0, sys_addr(periph_pkg::SYS_SCRATCH), d);

        test_name = "interrupt flag";
        intr_chk = 1'b1;
        exp_intr = 1'b1;
        bus_write(0, sys_addr(periph_pkg::SYS_INTR), 32'd1, 4'hf);
        bus_read(0, sys_addr(periph_pkg::SYS_INTR), 32'd1);
        exp_intr = 1'b0;
        bus_write(0, sys_addr(periph_pkg::SYS_INTR), 32'd0, 4'hf);
        bus_read(0, sys_addr(periph_pkg::SYS_INTR), 32'd0);
        intr_chk = 1'b0;

        test_name = "unmapped address";
        bad_addr = {9'h155, 21'($random(seed))};
        master_access(0, 1'b0, bad_addr, 32'd0, 4'hf, 1'b0, 32'd0, 1'b1, d2, c1);
        // error register reports a byte address
        bus_read(0, sys_addr(periph_pkg::SYS_BUSERR), 32'(bad_addr) * 32'd4);

        // both masters raise cyc on the same falling edge
        test_name = "arbitration";
        a = 8'd37;
        fork
            bus_read(0, mem_addr(a), ref_mem[a]);
            bus_read(1, sys_addr(periph_pkg::SYS_SCRATCH), d);
        join

        test_name = "power counter";
        master_access(0, 1'b0, sys_addr(periph_pkg::SYS_POWER), 32'd0, 4'hf,
                      1'b0, 32'd0, 1'b0, d, c1);
        b = 8'($random(seed) & 15);
        repeat (b) @(negedge clk);
        master_access(0, 1'b0, sys_addr(periph_pkg::SYS_POWER), 32'd0, 4'hf,
                      1'b0, 32'd0, 1'b0, d2, c2);
        a_power_delta : assert ((d2 - d) == 32'(c2 - c1))
        else begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", test_name, c2 - c1, d2 - d);
        end

        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule
